// File: verilog/p10_defs.svh
/* p10 command interpreter
   field lengths, protocol characters and slot count */

`ifndef P10_DEFS_SVH
`define P10_DEFS_SVH

// field lengths in characters
`define P10_CMD_LEN    8
`define P10_PRM_LEN    8
`define P10_DAT_LEN    6
`define P10_UNITS_LEN  4
`define P10_STR_LEN    20

// number of parameter slots
`define P10_PRM_COUNT  6

// request framing, start is a backtick
`define P10_START      8'h60
`define P10_CMD_DLM    "-"
`define P10_PRM_DLM    ":"
`define P10_DAT_DLM    ";"

// reply framing
`define P10_START_TX   ">"

`endif

// File: verilog/p10_pkg.sv
/* p10 shared types
   operation, error and slot response types plus the parameter table */

`include "p10_defs.svh"

package p10_pkg;

  // names right-aligned, zero-padded on the left
  typedef logic [`P10_PRM_LEN-1:0][7:0]   name_t;
  // most significant digit in the top nibble
  typedef logic [`P10_DAT_LEN-1:0][3:0]   bcd_t;
  typedef logic [`P10_UNITS_LEN-1:0][7:0] units_t;

  typedef enum logic {get, set} cmd_kind_t;

  typedef enum logic [1:0] {none, cmd_bad, prm_bad, data_bad} rx_err_t;

  typedef enum logic [1:0] {prm_ok, read_only, low, high} prm_err_t;

  typedef struct packed {
    cmd_kind_t kind;
    name_t     name;
    bcd_t      value;
    rx_err_t   err;
  } op_t;

  typedef struct packed {
    name_t  name;
    bcd_t   min;
    bcd_t   max;
    bcd_t   rst_val;
    units_t units;
    logic   writable;
  } prm_entry_t;

  // name, min, max, reset value, units, writable
  localparam prm_entry_t prm_table [`P10_PRM_COUNT] = '{
    '{"freq",    24'h000100, 24'h500000, 24'h010000, "Hz",  1'b1},
    '{"duty",    24'h000000, 24'h000050, 24'h000033, "%",   1'b1},
    '{"phase",   24'h000000, 24'h000359, 24'h000180, "deg", 1'b1},
    '{"ocd",     24'h000001, 24'h001000, 24'h000100, "A",   1'b1},
    '{"deadtim", 24'h000002, 24'h001000, 24'h000002, "ns",  1'b1},
    '{"current", 24'h000000, 24'h000100, 24'h000000, "A",   1'b0}
  };

  typedef struct packed {
    logic     hit;
    prm_err_t err;
    bcd_t     value;
    units_t   units;
  } slot_rsp_t;

endpackage

// File: verilog/p10_rx_parser.sv
/* p10 receive parser
   walks the request characters and emits one operation per ';' */

`timescale 1ns/10ps
`include "p10_defs.svh"

module p10_rx_parser (
  input  logic         clk,
  input  logic         fsm_rst,
  input  logic [7:0]   rxd,
  input  logic         rxv,
  input  logic         busy,
  output p10_pkg::op_t op,
  output logic         op_v
);

  typedef enum logic [2:0] {
    s_idle,
    s_cmd,
    s_prm,
    s_dat,
    s_drain
  } state_t;

  state_t state;
  logic   acc;
  logic   is_digit;

  logic [`P10_CMD_LEN-1:0][7:0]      cmd_buf;
  logic [$clog2(`P10_CMD_LEN+1)-1:0] cmd_cnt;
  logic [$clog2(`P10_PRM_LEN+1)-1:0] prm_cnt;
  logic [$clog2(`P10_DAT_LEN+1)-1:0] dat_cnt;

  // bytes during a reply are dropped
  assign acc      = rxv && !busy;
  assign is_digit = (rxd >= "0") && (rxd <= "9");

  //////////////////////////////////////////////////
  // character FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state <= s_idle;
      op_v  <= 1'b0;
    end else begin
      op_v <= 1'b0;
      if (acc) begin
        case (state)
          s_idle: begin
            if (rxd == `P10_START) begin
              state    <= s_cmd;
              cmd_buf  <= '0;
              cmd_cnt  <= '0;
              prm_cnt  <= '0;
              dat_cnt  <= '0;
              op.kind  <= p10_pkg::get;
              op.name  <= '0;
              op.value <= '0;
              op.err   <= p10_pkg::none;
            end
          end
          s_cmd: begin
            if (rxd == `P10_DAT_DLM) begin
              op.err <= p10_pkg::cmd_bad;
              op_v   <= 1'b1;
              state  <= s_idle;
            end else if (rxd == `P10_CMD_DLM) begin
              if (cmd_buf == "get") begin
                op.kind <= p10_pkg::get;
                state   <= s_prm;
              end else if (cmd_buf == "set") begin
                op.kind <= p10_pkg::set;
                state   <= s_prm;
              end else begin
                op.err <= p10_pkg::cmd_bad;
                state  <= s_drain;
              end
            end else if (cmd_cnt == `P10_CMD_LEN) begin
              op.err <= p10_pkg::cmd_bad;
              state  <= s_drain;
            end else begin
              cmd_buf <= {cmd_buf[`P10_CMD_LEN-2:0], rxd};
              cmd_cnt <= cmd_cnt + 1'b1;
            end
          end
          s_prm: begin
            if (rxd == `P10_DAT_DLM) begin
              // set needs a value
              if (op.kind == p10_pkg::set) op.err <= p10_pkg::prm_bad;
              op_v  <= 1'b1;
              state <= s_idle;
            end else if (rxd == `P10_PRM_DLM) begin
              if (op.kind == p10_pkg::set) begin
                state <= s_dat;
              end else begin
                op.err <= p10_pkg::prm_bad;
                state  <= s_drain;
              end
            end else if (prm_cnt == `P10_PRM_LEN) begin
              op.err <= p10_pkg::prm_bad;
              state  <= s_drain;
            end else begin
              op.name <= {op.name[`P10_PRM_LEN-2:0], rxd};
              prm_cnt <= prm_cnt + 1'b1;
            end
          end
          s_dat: begin
            if (rxd == `P10_DAT_DLM) begin
              if (dat_cnt == 0) op.err <= p10_pkg::data_bad;
              op_v  <= 1'b1;
              state <= s_idle;
            end else if (!is_digit || dat_cnt == `P10_DAT_LEN) begin
              op.err <= p10_pkg::data_bad;
              state  <= s_drain;
            end else begin
              op.value <= {op.value[`P10_DAT_LEN-2:0], rxd[3:0]};
              dat_cnt  <= dat_cnt + 1'b1;
            end
          end
          s_drain: begin
            // error already latched, wait for the end of the request
            if (rxd == `P10_DAT_DLM) begin
              op_v  <= 1'b1;
              state <= s_idle;
            end
          end
          default: state <= s_idle;
        endcase
      end
    end
  end

  // builder holds busy after an operation, so no second one can rise mid-reply
  op_v_busy_a: assert property (@(posedge clk) disable iff (fsm_rst)
    op_v |=> busy);

endmodule

// File: verilog/p10_prm_slot.sv
/* p10 parameter slot
   holds one parameter, matches its name and checks rights and range */

`timescale 1ns/10ps
`include "p10_defs.svh"

module p10_prm_slot #(
  parameter int SLOT = 0
) (
  input  logic               clk,
  input  logic               fsm_rst,
  input  p10_pkg::op_t       op,
  input  logic               op_v,
  output p10_pkg::slot_rsp_t rsp
);

  localparam p10_pkg::prm_entry_t ENTRY = p10_pkg::prm_table[SLOT];

  p10_pkg::bcd_t     val;
  p10_pkg::prm_err_t chk;
  logic              match;
  logic              wr_ok;

  assign match = op_v && (op.err == p10_pkg::none) && (op.name == ENTRY.name);

  // bcd digits order like binary, so a plain compare is a magnitude compare
  always_comb begin
    chk = p10_pkg::prm_ok;
    if (op.kind == p10_pkg::set) begin
      if (!ENTRY.writable) begin
        chk = p10_pkg::read_only;
      end else if (op.value < ENTRY.min) begin
        chk = p10_pkg::low;
      end else if (op.value > ENTRY.max) begin
        chk = p10_pkg::high;
      end
    end
  end

  assign wr_ok = match && (op.kind == p10_pkg::set) && (chk == p10_pkg::prm_ok);

  always_ff @(posedge clk) begin
    rsp.err   <= chk;
    rsp.value <= val;
    rsp.units <= ENTRY.units;
    if (fsm_rst) begin
      val     <= ENTRY.rst_val;
      rsp.hit <= 1'b0;
    end else begin
      rsp.hit <= match;
      if (wr_ok) val <= op.value;
    end
  end

  // stored value never leaves the table limits
  val_range_a: assert property (@(posedge clk) disable iff (fsm_rst)
    (val >= ENTRY.min) && (val <= ENTRY.max));

endmodule

// File: verilog/p10_tx_builder.sv
/* p10 transmit builder
   picks the answering slot, composes the reply and streams it under cts */

`timescale 1ns/10ps
`include "p10_defs.svh"

module p10_tx_builder (
  input  logic               clk,
  input  logic               fsm_rst,
  input  p10_pkg::op_t       op,
  input  logic               op_v,
  input  p10_pkg::slot_rsp_t slot_rsp [`P10_PRM_COUNT],
  input  logic               cts,
  output logic               busy,
  output logic [7:0]         txd,
  output logic               txv
);

  // '>' + name + body + ';' CR LF
  localparam int RAW_LEN = 1 + `P10_PRM_LEN + `P10_STR_LEN + 3;
  localparam int PTR_W   = $clog2(RAW_LEN);
  localparam int PAD_LEN = `P10_STR_LEN - 1 - `P10_DAT_LEN - `P10_UNITS_LEN;

  typedef enum logic [1:0] {
    s_idle,
    s_load,
    s_pack,
    s_send
  } state_t;

  state_t                       state;
  logic [`P10_PRM_COUNT-1:0]    hits;
  p10_pkg::prm_err_t            sel_err;
  p10_pkg::bcd_t                sel_value;
  p10_pkg::units_t              sel_units;
  logic [`P10_DAT_LEN-1:0][7:0] digits;
  logic [`P10_STR_LEN-1:0][7:0] body;
  p10_pkg::name_t               shown_name;
  logic [RAW_LEN-1:0][7:0]      raw_next;
  logic [RAW_LEN-1:0][7:0]      raw;
  logic [7:0]                   line [RAW_LEN];
  logic [PTR_W-1:0]             cnt;
  logic [PTR_W-1:0]             wr_ptr;
  logic [PTR_W-1:0]             rd_ptr;

  assign busy = op_v || (state != s_idle);

  //////////////////////////////////////////////////
  // reply composition
  //////////////////////////////////////////////////

  always_comb begin
    hits      = '0;
    sel_err   = p10_pkg::prm_ok;
    sel_value = '0;
    sel_units = '0;
    for (int i = 0; i < `P10_PRM_COUNT; i++) begin
      hits[i] = slot_rsp[i].hit;
      if (slot_rsp[i].hit) begin
        sel_err   = slot_rsp[i].err;
        sel_value = slot_rsp[i].value;
        sel_units = slot_rsp[i].units;
      end
    end
  end

  // leading zeros blanked, last digit always shown
  always_comb begin
    logic seen;
    seen = 1'b0;
    for (int i = `P10_DAT_LEN - 1; i >= 0; i--) begin
      if (seen || sel_value[i] != 4'h0 || i == 0) begin
        digits[i] = {4'h3, sel_value[i]};
        seen      = 1'b1;
      end else begin
        digits[i] = 8'h00;
      end
    end
  end

  always_comb begin
    shown_name = '0;
    body       = '0;
    if (op.err != p10_pkg::none) begin
      case (op.err)
        p10_pkg::cmd_bad: body = "bad command";
        p10_pkg::prm_bad: body = "bad parameter";
        default:          body = "bad data";
      endcase
    end else if (hits == '0) begin
      body = "parameter not found";
    end else if (sel_err != p10_pkg::prm_ok) begin
      case (sel_err)
        p10_pkg::read_only: body = "read-only";
        p10_pkg::low:       body = "value too low";
        default:            body = "value too high";
      endcase
    end else if (op.kind == p10_pkg::set) begin
      shown_name = op.name;
      body       = ": parameter set";
    end else begin
      shown_name = op.name;
      body       = {{PAD_LEN{8'h00}}, `P10_PRM_DLM, digits, sel_units};
    end
  end

  // zero bytes are squeezed out while packing
  assign raw_next = {`P10_START_TX, shown_name, body, `P10_DAT_DLM, 8'h0d, 8'h0a};

  //////////////////////////////////////////////////
  // pack and send
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state == s_pack && raw[RAW_LEN-1] != 8'h00) begin
      line[wr_ptr] <= raw[RAW_LEN-1];
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state <= s_idle;
      txv   <= 1'b0;
    end else begin
      txv <= 1'b0;
      case (state)
        s_idle: begin
          if (op_v) state <= s_load;
        end
        s_load: begin
          // slot responses valid here
          raw    <= raw_next;
          cnt    <= '0;
          wr_ptr <= '0;
          state  <= s_pack;
        end
        s_pack: begin
          raw <= {raw[RAW_LEN-2:0], 8'h00};
          cnt <= cnt + 1'b1;
          if (raw[RAW_LEN-1] != 8'h00) wr_ptr <= wr_ptr + 1'b1;
          if (cnt == PTR_W'(RAW_LEN - 1)) begin
            rd_ptr <= '0;
            state  <= s_send;
          end
        end
        s_send: begin
          if (cts) begin
            txd    <= line[rd_ptr];
            txv    <= 1'b1;
            rd_ptr <= rd_ptr + 1'b1;
            // LF is the last packed byte
            if (rd_ptr == wr_ptr - 1'b1) state <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // names in the table are distinct
  one_hit_a: assert property (@(posedge clk) disable iff (fsm_rst) $onehot0(hits));

endmodule

// File: verilog/p10_top.sv
/* p10 command interpreter top
   parser, parameter slots and reply builder */

`timescale 1ns/10ps
`include "p10_defs.svh"

module p10_top (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic [7:0] rxd,
  input  logic       rxv,
  output logic [7:0] txd,
  output logic       txv,
  input  logic       cts
);

  p10_pkg::op_t       op;
  logic               op_v;
  logic               busy;
  p10_pkg::slot_rsp_t slot_rsp [`P10_PRM_COUNT];

  p10_rx_parser u_parser (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rxd     (rxd),
    .rxv     (rxv),
    .busy    (busy),
    .op      (op),
    .op_v    (op_v)
  );

  // one slot per table entry
  for (genvar i = 0; i < `P10_PRM_COUNT; i++) begin : g_slot
    p10_prm_slot #(
      .SLOT (i)
    ) u_slot (
      .clk     (clk),
      .fsm_rst (fsm_rst),
      .op      (op),
      .op_v    (op_v),
      .rsp     (slot_rsp[i])
    );
  end

  p10_tx_builder u_builder (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .op       (op),
    .op_v     (op_v),
    .slot_rsp (slot_rsp),
    .cts      (cts),
    .busy     (busy),
    .txd      (txd),
    .txv      (txv)
  );

endmodule

// File: testbench/p10_tb.sv
/* p10 testbench
   table of get/set requests with expected reply lines, random cts */

`timescale 1ns/10ps
`include "p10_defs.svh"

module p10_tb;

  localparam int REPLY_TIMEOUT = 2000;
  localparam int HOLD_CYCLES   = 25;

  logic       clk;
  logic       fsm_rst;
  logic [7:0] rxd;
  logic       rxv;
  logic       cts;
  logic [7:0] txd;
  logic       txv;

  integer seed;
  int     checks;
  int     mismatches;
  int     timeouts;

  // request table, one entry per index
  string pre_q [$];
  string req_q [$];
  string exp_q [$];
  bit    hold_q [$];

  logic [7:0] got [$];

  p10_top dut0 (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rxd     (rxd),
    .rxv     (rxv),
    .txd     (txd),
    .txv     (txv),
    .cts     (cts)
  );

  always #10 clk = ~clk;

  task automatic add_case(input string pre, input string req, input string exp, input bit hold);
    pre_q.push_back(pre);
    req_q.push_back(req);
    exp_q.push_back(exp);
    hold_q.push_back(hold);
  endtask

  task automatic fill_table();
    // reset values
    add_case("", "get-freq;", ">freq:10000Hz;", 0);
    add_case("", "get-duty;", ">duty:33%;", 0);
    add_case("", "get-phase;", ">phase:180deg;", 0);
    add_case("", "get-ocd;", ">ocd:100A;", 0);
    add_case("", "get-deadtim;", ">deadtim:2ns;", 0);
    add_case("", "get-current;", ">current:0A;", 0);
    // writes inside the limits, edges included
    add_case("", "set-freq:250000;", ">freq: parameter set;", 0);
    add_case("", "get-freq;", ">freq:250000Hz;", 0);
    add_case("", "set-freq:100;", ">freq: parameter set;", 0);
    add_case("", "get-freq;", ">freq:100Hz;", 0);
    add_case("", "set-freq:500000;", ">freq: parameter set;", 0);
    add_case("", "get-freq;", ">freq:500000Hz;", 0);
    add_case("", "set-duty:0;", ">duty: parameter set;", 0);
    add_case("", "get-duty;", ">duty:0%;", 0);
    add_case("", "set-duty:50;", ">duty: parameter set;", 0);
    add_case("", "set-phase:359;", ">phase: parameter set;", 0);
    add_case("", "set-ocd:0001;", ">ocd: parameter set;", 0);
    add_case("", "get-ocd;", ">ocd:1A;", 0);
    add_case("", "set-deadtim:1000;", ">deadtim: parameter set;", 0);
    add_case("", "get-deadtim;", ">deadtim:1000ns;", 0);
    // out of range, old value kept
    add_case("", "set-freq:99;", ">value too low;", 0);
    add_case("", "set-freq:500001;", ">value too high;", 0);
    add_case("", "get-freq;", ">freq:500000Hz;", 0);
    add_case("", "set-ocd:0;", ">value too low;", 0);
    add_case("", "set-phase:360;", ">value too high;", 0);
    add_case("", "get-phase;", ">phase:359deg;", 0);
    add_case("", "set-duty:51;", ">value too high;", 0);
    add_case("", "get-duty;", ">duty:50%;", 0);
    // rights and unknown names
    add_case("", "set-current:5;", ">read-only;", 0);
    add_case("", "get-current;", ">current:0A;", 0);
    add_case("", "get-volt;", ">parameter not found;", 0);
    add_case("", "set-volt:5;", ">parameter not found;", 0);
    // malformed requests
    add_case("", "put-freq;", ">bad command;", 0);
    add_case("", "getfreq;", ">bad command;", 0);
    add_case("", "abcdefghij-duty;", ">bad command;", 0);
    add_case("", "get-frequency0;", ">bad parameter;", 0);
    add_case("", "get-duty:5;", ">bad parameter;", 0);
    add_case("", "set-duty;", ">bad parameter;", 0);
    add_case("", "set-duty:4x;", ">bad data;", 0);
    add_case("", "set-freq:1234567;", ">bad data;", 0);
    add_case("", "set-duty:;", ">bad data;", 0);
    add_case("", "get-duty;", ">duty:50%;", 0);
    // stalled transmit and leading garbage
    add_case("zz;-:", "get-freq;", ">freq:500000Hz;", 1);
    add_case("x9", "set-duty:12;", ">duty: parameter set;", 1);
    add_case("", "get-duty;", ">duty:12%;", 0);
  endtask

  // one strobe, then a random idle gap
  task automatic send_byte(input logic [7:0] b);
    int gap;
    rxd = b;
    rxv = 1'b1;
    @(negedge clk);
    rxv = 1'b0;
    rxd = 8'h00;
    gap = $random(seed) & 3;
    repeat (gap) @(negedge clk);
  endtask

  task automatic send_request(input string pre, input string req);
    for (int i = 0; i < pre.len(); i++) begin
      send_byte(pre[i]);
    end
    send_byte(`P10_START);
    for (int i = 0; i < req.len(); i++) begin
      send_byte(req[i]);
    end
  endtask

  // sampled on the falling edge, cts chosen for the next rising edge
  task automatic collect_line(input bit hold, output bit timed_out);
    int cycles;
    int hold_left;
    bit held;
    bit done;
    got.delete();
    cycles    = 0;
    hold_left = 0;
    held      = 1'b0;
    done      = 1'b0;
    timed_out = 1'b0;
    while (!done && !timed_out) begin
      if (hold_left > 0) begin
        checks++;
        assert (!txv) else begin
          mismatches++;
          $display("error at %0t: txv high while cts held low", $time);
        end
      end
      if (txv) begin
        got.push_back(txd);
        if (txd == 8'h0a) done = 1'b1;
      end
      if (hold_left > 0) hold_left--;
      if (hold && !held && got.size() == 5) begin
        held      = 1'b1;
        hold_left = HOLD_CYCLES;
      end
      cts = (hold_left > 0) ? 1'b0 : (($random(seed) & 3) != 0);
      if (!done) begin
        cycles++;
        if (cycles > REPLY_TIMEOUT) timed_out = 1'b1;
        else @(negedge clk);
      end
    end
  endtask

  function automatic bit line_matches(input string exp);
    if (got.size() != exp.len() + 2) return 1'b0;
    for (int i = 0; i < exp.len(); i++) begin
      if (got[i] != exp[i]) return 1'b0;
    end
    return (got[exp.len()] == 8'h0d) && (got[exp.len() + 1] == 8'h0a);
  endfunction

  function automatic string line_text();
    string s;
    s = "";
    foreach (got[i]) begin
      if (got[i] == 8'h0d) s = {s, "<cr>"};
      else if (got[i] == 8'h0a) s = {s, "<lf>"};
      else s = $sformatf("%s%c", s, got[i]);
    end
    return s;
  endfunction

  initial begin
    bit timed_out;
    bit ok;
    clk        = 1'b0;
    fsm_rst    = 1'b1;
    rxd        = 8'h00;
    rxv        = 1'b0;
    cts        = 1'b1;
    seed       = 32'h9079b5cc;
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    fill_table();
    repeat (5) @(negedge clk);
    fsm_rst = 1'b0;
    @(negedge clk);

    for (int n = 0; n < req_q.size(); n++) begin
      send_request(pre_q[n], req_q[n]);
      collect_line(hold_q[n], timed_out);
      if (timed_out) begin
        timeouts++;
        $display("timeout: request %0d '%s' got no complete reply line in %0d cycles",
                 n, req_q[n], REPLY_TIMEOUT);
        break;
      end
      checks++;
      ok = line_matches(exp_q[n]);
      assert (ok) else begin
        mismatches++;
        $display("error at %0t: request %0d '%s' expected '%s<cr><lf>' got '%s'",
                 $time, n, req_q[n], exp_q[n], line_text());
      end
    end

    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+verilog
verilog/p10_pkg.sv
verilog/p10_rx_parser.sv
verilog/p10_prm_slot.sv
verilog/p10_tx_builder.sv
verilog/p10_top.sv
testbench/p10_tb.sv

// File: Makefile
# Verilator build and run for the p10 command interpreter

VERILATOR ?= verilator
TOP       ?= p10_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
